//--- all.f
+incdir+hdl
hdl/rv_isa_pkg.sv
hdl/core_pkg.sv
hdl/fetch_unit.sv
hdl/decode_unit.sv
hdl/register_file.sv
hdl/execute_unit.sv
hdl/csr_unit.sv
hdl/commit_unit.sv
hdl/rv_core.sv
verification/imem_model.sv
verification/core_tb.sv

//--- verification/core_tb.sv
`include "core_defs.svh"

module core_tb
	import rv_isa_pkg::*;
();

	localparam int CLK_PERIOD = 40;
	localparam int DRIVE_DELAY = 2;
	localparam int RESET_CYCLES = 4;
	localparam int SEED = 59919;
	localparam int N_TESTS = 36;
	localparam int MAX_PROG_CYCLES = 32;
	localparam int HOLD_CYCLES = 8;
	localparam int MARGIN_CYCLES = 40;
	localparam int WATCHDOG_CYCLES =
		N_TESTS * (MAX_PROG_CYCLES + RESET_CYCLES + HOLD_CYCLES) + MARGIN_CYCLES;

	logic clk;
	logic reset;
	logic [31:0] imem_addr;
	rv_inst_u imem_data;
	logic [31:0] pc;
	logic finished;
	logic [31:0] halt_ret;

	string test_name;
	logic [31:0] exp_ret;
	logic ret_valid;
	logic trace_on;
	logic [31:0] exp_trace [0:63];
	int trace_len;
	int trace_pos;
	int prog_len;
	int errors;
	int test_errors;
	int npass;
	int nfail;

	rv_core u_rv_core (
		.clk(clk),
		.reset(reset),
		.imem_addr(imem_addr),
		.imem_data(imem_data),
		.pc(pc),
		.finished(finished),
		.halt_ret(halt_ret)
	);

	imem_model u_imem (
		.addr(imem_addr),
		.data(imem_data)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// expected pc trace index counts cycles from reset release.
	always @(posedge clk) begin
		if (!reset) begin
			trace_pos <= 0;
		end else begin
			trace_pos <= trace_pos + 1;
		end
	end

	task automatic record_error();
		errors++;
		test_errors++;
	endtask

	task automatic report_mismatch(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		record_error();
		$display("FAIL %s %s expected %h actual %h", test_name, what, expected, actual);
	endtask

	a_halt_ret: assert property (@(posedge clk) disable iff (!reset)
		(finished && ret_valid) |-> (halt_ret == exp_ret))
		else report_mismatch("halt_ret", exp_ret, $sampled(halt_ret));

	a_pc_hold: assert property (@(posedge clk) disable iff (!reset)
		finished |=> $stable(pc))
		else begin
			record_error();
			$display("FAIL %s pc moved to %h after the core halted", test_name, pc);
		end

	a_pc_trace: assert property (@(posedge clk) disable iff (!reset)
		(trace_on && !finished) |-> (trace_pos < trace_len && pc == exp_trace[trace_pos]))
		else report_mismatch("pc trace", exp_trace[$sampled(trace_pos)], $sampled(pc));

	function automatic rv_inst_u r_inst(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
		input logic [6:0] opc);
		rv_inst_u w;
		w.r = '{f7, rs2, rs1, f3, rd, opc};
		return w;
	endfunction

	function automatic rv_inst_u i_inst(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		rv_inst_u w;
		w.i = '{imm, rs1, f3, rd, opc};
		return w;
	endfunction

	function automatic rv_inst_u b_inst(input int off, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		rv_inst_u w;
		logic [31:0] o;
		o = off;
		w.b = '{o[12], o[10:5], rs2, rs1, f3, o[4:1], o[11], BRANCH};
		return w;
	endfunction

	function automatic rv_inst_u u_inst(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] opc);
		rv_inst_u w;
		w.u = '{imm, rd, opc};
		return w;
	endfunction

	function automatic rv_inst_u j_inst(input int off, input logic [4:0] rd);
		rv_inst_u w;
		logic [31:0] o;
		o = off;
		w.j = '{o[20], o[10:1], o[11], o[19:12], rd, JAL};
		return w;
	endfunction

	function automatic rv_inst_u sys_inst(input logic [11:0] f12);
		return i_inst(f12, 5'd0, F3_PRIV, 5'd0, SYSTEM);
	endfunction

	// reference arithmetic for the base integer ops.
	function automatic logic [31:0] alu_expect(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			F3_ADD_SUB: return alt ? a - b : a + b;
			F3_SLL: return a << b[4:0];
			F3_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			F3_SLTU: return (a < b) ? 32'd1 : 32'd0;
			F3_XOR: return a ^ b;
			F3_SRL_SRA: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
			F3_OR: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
		input logic [31:0] b);
		case (f3)
			F3_BEQ: return a == b;
			F3_BNE: return a != b;
			F3_BLT: return $signed(a) < $signed(b);
			F3_BGE: return $signed(a) >= $signed(b);
			F3_BLTU: return a < b;
			F3_BGEU: return a >= b;
			default: return 1'b0;
		endcase
	endfunction

	task automatic emit(input rv_inst_u w);
		u_imem.mem[prog_len] = w;
		prog_len++;
	endtask

	// lui then addi with the upper part rounded for a negative low part.
	task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
		logic [31:0] hi;
		hi = (value + 32'h800) >> 12;
		emit(u_inst(hi[19:0], rd, LUI));
		emit(i_inst(value[11:0], rd, F3_ADD_SUB, rd, OP_IMM));
	endtask

	task automatic expect_pc(input int idx);
		exp_trace[trace_len] = `RESET_PC + 32'(idx * 4);
		trace_len++;
	endtask

	task automatic start_test(input string name);
		@(posedge clk);
		#DRIVE_DELAY reset = 0;
		test_name = name;
		test_errors = 0;
		ret_valid = 0;
		trace_on = 0;
		trace_len = 0;
		prog_len = 0;
		u_imem.clear();
	endtask

	task automatic release_reset();
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY reset = 1;
	endtask

	task automatic run_to_halt();
		@(posedge clk);
		#DRIVE_DELAY;
		while (!finished) begin
			@(posedge clk);
			#DRIVE_DELAY;
		end
		repeat (HOLD_CYCLES) @(posedge clk); // pc must hold meanwhile.
		#DRIVE_DELAY;
	endtask

	task automatic finish_test(input logic [31:0] actual);
		if (test_errors == 0) begin
			npass++;
			$display("PASS %s expected %h actual %h", test_name, exp_ret, actual);
		end else begin
			nfail++;
			$display("FAIL %s expected %h actual %h", test_name, exp_ret, actual);
		end
	endtask

	task automatic alu_test(input logic [2:0] f3, input logic alt, input logic imm_form);
		logic [31:0] a;
		logic [31:0] b;
		logic [11:0] imm;
		a = $urandom;
		b = $urandom;
		imm = $urandom;
		start_test($sformatf("alu %s f3=%0d alt=%0d", imm_form ? "op_imm" : "op", f3, alt));
		load_const(5'd5, a);
		if (imm_form) begin
			if (f3 == F3_SLL || f3 == F3_SRL_SRA) begin
				imm = {1'b0, alt, 5'b0, b[4:0]}; // shamt form.
			end
			b = {{20{imm[11]}}, imm};
			emit(i_inst(imm, 5'd5, f3, 5'd10, OP_IMM));
		end else begin
			load_const(5'd6, b);
			emit(r_inst({1'b0, alt, 5'b0}, 5'd6, 5'd5, f3, 5'd10, OP));
		end
		emit(sys_inst(SYS_EBREAK));
		exp_ret = alu_expect(f3, alt, a, b);
		ret_valid = 1;
		release_reset();
		run_to_halt();
		finish_test(halt_ret);
	endtask

	task automatic branch_test(input logic [2:0] f3, input logic want);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] coin;
		a = 0;
		b = 1;
		while (branch_taken(f3, a, b) != want) begin
			a = $urandom;
			coin = $urandom;
			b = coin[0] ? a : $urandom;
		end
		start_test($sformatf("branch f3=%0d %s", f3, want ? "taken" : "not_taken"));
		load_const(5'd5, a);
		load_const(5'd6, b);
		emit(b_inst(12, 5'd6, 5'd5, f3));
		emit(i_inst(12'd1, 5'd0, F3_ADD_SUB, 5'd10, OP_IMM));
		emit(sys_inst(SYS_EBREAK));
		emit(i_inst(12'd2, 5'd0, F3_ADD_SUB, 5'd10, OP_IMM));
		emit(sys_inst(SYS_EBREAK));
		for (int i = 0; i < 5; i++) begin
			expect_pc(i);
		end
		expect_pc(want ? 7 : 5);
		expect_pc(want ? 8 : 6);
		exp_ret = want ? 32'd2 : 32'd1;
		ret_valid = 1;
		trace_on = 1;
		release_reset();
		run_to_halt();
		finish_test(halt_ret);
	endtask

	task automatic jump_test();
		start_test("jal_jalr");
		emit(j_inst(12, 5'd1));
		emit(i_inst(12'hfff, 5'd0, F3_ADD_SUB, 5'd10, OP_IMM));
		emit(sys_inst(SYS_EBREAK));
		emit(u_inst(20'd0, 5'd5, AUIPC));
		emit(i_inst(12'd17, 5'd5, F3_ADD_SUB, 5'd5, OP_IMM)); // odd jalr base.
		emit(i_inst(12'd0, 5'd5, 3'd0, 5'd7, JALR));
		emit(sys_inst(SYS_EBREAK));
		emit(r_inst(7'b0100000, 5'd1, 5'd7, F3_ADD_SUB, 5'd10, OP));
		emit(sys_inst(SYS_EBREAK));
		expect_pc(0);
		for (int i = 3; i < 6; i++) begin
			expect_pc(i);
		end
		expect_pc(7);
		expect_pc(8);
		exp_ret = (`RESET_PC + 32'd24) - (`RESET_PC + 32'd4); // the two link values.
		ret_valid = 1;
		trace_on = 1;
		release_reset();
		run_to_halt();
		finish_test(halt_ret);
	endtask

	task automatic upper_test();
		logic [31:0] r1;
		logic [31:0] r2;
		r1 = $urandom;
		r2 = $urandom;
		start_test("lui_auipc_x0");
		emit(u_inst(r1[19:0], 5'd5, LUI));
		emit(u_inst(r2[19:0], 5'd6, AUIPC));
		emit(i_inst(12'd5, 5'd0, F3_ADD_SUB, 5'd0, OP_IMM));
		emit(u_inst(r1[19:0], 5'd0, LUI));
		emit(r_inst(7'd0, 5'd6, 5'd5, F3_ADD_SUB, 5'd10, OP));
		emit(r_inst(7'd0, 5'd0, 5'd10, F3_ADD_SUB, 5'd10, OP));
		emit(sys_inst(SYS_EBREAK));
		for (int i = 0; i < 7; i++) begin
			expect_pc(i);
		end
		exp_ret = {r1[19:0], 12'b0} + (`RESET_PC + 32'd4) + {r2[19:0], 12'b0};
		ret_valid = 1;
		trace_on = 1;
		release_reset();
		run_to_halt();
		finish_test(halt_ret);
	endtask

	task automatic trap_test();
		start_test("csr_ecall_mret");
		load_const(5'd5, `RESET_PC + 32'h40); // handler at word 16.
		emit(i_inst(`CSR_MTVEC, 5'd5, F3_CSRRW, 5'd0, SYSTEM));
		emit(sys_inst(SYS_ECALL));
		emit(i_inst(12'h100, 5'd10, F3_ADD_SUB, 5'd10, OP_IMM));
		emit(sys_inst(SYS_EBREAK));
		prog_len = 16;
		emit(i_inst(`CSR_MCAUSE, 5'd0, F3_CSRRS, 5'd6, SYSTEM));
		emit(i_inst(`CSR_MEPC, 5'd0, F3_CSRRS, 5'd7, SYSTEM));
		emit(i_inst(12'd4, 5'd7, F3_ADD_SUB, 5'd7, OP_IMM));
		emit(i_inst(`CSR_MEPC, 5'd7, F3_CSRRW, 5'd0, SYSTEM));
		emit(i_inst(`CSR_MCAUSE, 5'd6, F3_CSRRC, 5'd0, SYSTEM)); // clears mcause.
		emit(i_inst(`CSR_MCAUSE, 5'd0, F3_CSRRS, 5'd9, SYSTEM));
		emit(r_inst(7'd0, 5'd7, 5'd6, F3_ADD_SUB, 5'd10, OP));
		emit(r_inst(7'd0, 5'd9, 5'd10, F3_ADD_SUB, 5'd10, OP));
		emit(sys_inst(SYS_MRET));
		for (int i = 0; i < 4; i++) begin
			expect_pc(i);
		end
		for (int i = 16; i < 25; i++) begin
			expect_pc(i);
		end
		expect_pc(4);
		expect_pc(5);
		// mcause plus the bumped mepc plus a cleared mcause.
		exp_ret = 32'd11 + (`RESET_PC + 32'd12 + 32'd4) + 32'h100;
		ret_valid = 1;
		trace_on = 1;
		release_reset();
		run_to_halt();
		finish_test(halt_ret);
	endtask

	task automatic halt_test();
		logic [31:0] v;
		v = $urandom;
		start_test("ebreak_halt");
		load_const(5'd10, v);
		emit(sys_inst(SYS_EBREAK));
		emit(i_inst(12'd1, 5'd10, F3_ADD_SUB, 5'd10, OP_IMM));
		emit(i_inst(`CSR_MTVEC, 5'd10, F3_CSRRW, 5'd10, SYSTEM));
		emit(j_inst(-12, 5'd0));
		exp_ret = v;
		ret_valid = 1;
		release_reset();
		run_to_halt();
		reset = 0; // a0 survives reset and is read back by a lone ebreak.
		prog_len = 0;
		emit(sys_inst(SYS_EBREAK));
		release_reset();
		run_to_halt();
		finish_test(halt_ret);
	endtask

	task automatic reset_test();
		start_test("reset_mid_run");
		emit(i_inst(12'd1, 5'd10, F3_ADD_SUB, 5'd10, OP_IMM));
		emit(i_inst(12'd1, 5'd10, F3_ADD_SUB, 5'd10, OP_IMM));
		emit(sys_inst(SYS_EBREAK)); // parks away from the reset address.
		exp_ret = `RESET_PC;
		release_reset();
		repeat (10) @(posedge clk);
		#DRIVE_DELAY reset = 0;
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY reset = 1;
		#(CLK_PERIOD / 4);
		assert (pc == `RESET_PC) else report_mismatch("pc after reset", `RESET_PC, pc);
		assert (!finished) else begin
			record_error();
			$display("FAIL %s finished was still high after reset release", test_name);
		end
		finish_test(pc);
	endtask

	initial begin
		logic [2:0] br_f3 [0:5];
		br_f3 = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
		clk = 0;
		reset = 0;
		test_name = "idle";
		exp_ret = '0;
		ret_valid = 0;
		trace_on = 0;
		trace_len = 0;
		prog_len = 0;
		errors = 0;
		test_errors = 0;
		npass = 0;
		nfail = 0;
		void'($urandom(SEED));
		u_imem.clear();
		for (int f3 = 0; f3 < 8; f3++) begin
			for (int alt = 0; alt < 2; alt++) begin
				if (alt == 0 || f3 == 0 || f3 == 5) begin
					alu_test(f3[2:0], alt[0], 1'b0);
				end
				if (alt == 0 || f3 == 5) begin
					alu_test(f3[2:0], alt[0], 1'b1);
				end
			end
		end
		for (int k = 0; k < 6; k++) begin
			branch_test(br_f3[k], 1'b1);
			branch_test(br_f3[k], 1'b0);
		end
		jump_test();
		upper_test();
		trap_test();
		halt_test();
		reset_test();
		$display("tests %0d, passed %0d, failed %0d, check errors %0d",
			npass + nfail, npass, nfail, errors);
		if (errors == 0 && nfail == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired after %0d cycles, core never finished in test %s",
			WATCHDOG_CYCLES, test_name);
		$display(">>> FAIL");
		$finish;
	end

endmodule

//--- verification/imem_model.sv
module imem_model
	import rv_isa_pkg::*;
(
	input logic [31:0] addr,
	output rv_inst_u data
);

	localparam int DEPTH = 64;

	rv_inst_u mem [0:DEPTH-1];

	// opcode zero decodes as a nop, the upper bits carry the word index.
	task automatic clear();
		for (int i = 0; i < DEPTH; i++) begin
			mem[i] = {i[24:0], 7'b0000000};
		end
	endtask

	assign data = mem[addr[7:2]]; // word index inside a 256 byte window.

endmodule

//--- hdl/rv_core.sv
`include "core_defs.svh"

module rv_core
	import rv_isa_pkg::*;
	import core_pkg::*;
(
	input logic clk,
	input logic reset,
	output logic [`XLEN-1:0] imem_addr,
	input rv_inst_u imem_data,
	output logic [`XLEN-1:0] pc,
	output logic finished,
	output logic [`XLEN-1:0] halt_ret
);

	decoded_t dec;
	exec_result_t ex;
	redirect_t branch_redirect;
	redirect_t trap_redirect;
	logic [`XLEN-1:0] rs1_val;
	logic [`XLEN-1:0] rs2_val;
	logic [`XLEN-1:0] csr_rdata;
	logic [`XLEN-1:0] a0;
	logic wb_en;
	logic [4:0] wb_addr;
	logic [`XLEN-1:0] wb_data;
	logic halt;

	assign imem_addr = pc;
	assign branch_redirect.valid = ex.taken;
	assign branch_redirect.target = ex.target;

	fetch_unit u_fetch (
		.clk(clk),
		.reset(reset),
		.halt(halt),
		.branch_redirect(branch_redirect),
		.trap_redirect(trap_redirect),
		.pc(pc)
	);

	decode_unit u_decode (
		.inst(imem_data),
		.dec(dec)
	);

	register_file u_regs (
		.clk(clk),
		.rs1_addr(dec.rs1),
		.rs2_addr(dec.rs2),
		.rs1_val(rs1_val),
		.rs2_val(rs2_val),
		.wb_en(wb_en),
		.wb_addr(wb_addr),
		.wb_data(wb_data),
		.a0(a0)
	);

	execute_unit u_exec (
		.pc(pc),
		.dec(dec),
		.rs1_val(rs1_val),
		.rs2_val(rs2_val),
		.ex(ex)
	);

	csr_unit u_csr (
		.clk(clk),
		.reset(reset),
		.halt(halt),
		.pc(pc),
		.dec(dec),
		.rs1_val(rs1_val),
		.csr_rdata(csr_rdata),
		.trap_redirect(trap_redirect)
	);

	commit_unit u_commit (
		.clk(clk),
		.reset(reset),
		.dec(dec),
		.ex(ex),
		.csr_rdata(csr_rdata),
		.a0(a0),
		.wb_en(wb_en),
		.wb_addr(wb_addr),
		.wb_data(wb_data),
		.halt(halt),
		.finished(finished),
		.halt_ret(halt_ret)
	);

endmodule

//--- hdl/commit_unit.sv
`include "core_defs.svh"

module commit_unit
	import core_pkg::*;
(
	input logic clk,
	input logic reset,
	input decoded_t dec,
	input exec_result_t ex,
	input logic [`XLEN-1:0] csr_rdata,
	input logic [`XLEN-1:0] a0,
	output logic wb_en,
	output logic [4:0] wb_addr,
	output logic [`XLEN-1:0] wb_data,
	output logic halt,
	output logic finished,
	output logic [`XLEN-1:0] halt_ret
);

	assign wb_en = dec.reg_wen && !finished; // no writes once halted.
	assign wb_addr = dec.rd;
	assign wb_data = (dec.csr_op != CSR_NONE) ? csr_rdata : ex.result; // old csr value.
	assign halt = finished;

	always_ff @(posedge clk) begin
		if (!reset) begin
			finished <= 1'b0;
			halt_ret <= '0;
		end else if (dec.is_ebreak && !finished) begin
			finished <= 1'b1;
			halt_ret <= a0;
		end
	end

endmodule

//--- hdl/csr_unit.sv
`include "core_defs.svh"

module csr_unit
	import core_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic halt,
	input logic [`XLEN-1:0] pc,
	input decoded_t dec,
	input logic [`XLEN-1:0] rs1_val,
	output logic [`XLEN-1:0] csr_rdata,
	output redirect_t trap_redirect
);

	logic [`XLEN-1:0] mtvec;
	logic [`XLEN-1:0] mepc;
	logic [`XLEN-1:0] mcause;
	logic [`XLEN-1:0] csr_wdata;

	always_comb begin
		case (dec.csr_addr)
			`CSR_MTVEC: csr_rdata = mtvec;
			`CSR_MEPC: csr_rdata = mepc;
			`CSR_MCAUSE: csr_rdata = mcause;
			default: csr_rdata = '0;
		endcase
	end

	always_comb begin
		case (dec.csr_op)
			CSR_WRITE: csr_wdata = rs1_val;
			CSR_SET: csr_wdata = csr_rdata | rs1_val;
			CSR_CLEAR: csr_wdata = csr_rdata & ~rs1_val;
			default: csr_wdata = csr_rdata;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			mtvec <= '0;
			mepc <= '0;
			mcause <= '0;
		end else if (!halt) begin
			if (dec.is_ecall) begin
				mepc <= pc;
				mcause <= `MCAUSE_ECALL;
			end else if (dec.csr_op != CSR_NONE) begin
				case (dec.csr_addr)
					`CSR_MTVEC: mtvec <= csr_wdata;
					`CSR_MEPC: mepc <= csr_wdata;
					`CSR_MCAUSE: mcause <= csr_wdata;
					default: mtvec <= mtvec; // unmapped address ignored.
				endcase
			end
		end
	end

	assign trap_redirect.valid = dec.is_ecall || dec.is_mret;
	assign trap_redirect.target = dec.is_ecall ? mtvec : mepc;

endmodule

//--- hdl/execute_unit.sv
`include "core_defs.svh"

module execute_unit
	import rv_isa_pkg::*;
	import core_pkg::*;
(
	input logic [`XLEN-1:0] pc,
	input decoded_t dec,
	input logic [`XLEN-1:0] rs1_val,
	input logic [`XLEN-1:0] rs2_val,
	output exec_result_t ex
);

	logic [`XLEN-1:0] op_a;
	logic [`XLEN-1:0] op_b;
	logic [4:0] shamt;
	logic [`XLEN-1:0] alu_out;
	logic [`XLEN-1:0] pc_plus4;
	logic [`XLEN-1:0] pc_target;
	logic [`XLEN-1:0] jalr_target;
	logic br_eq;
	logic br_lt;
	logic br_ltu;
	logic br_cond;

	assign op_a = dec.a_sel_pc ? pc : rs1_val;
	assign op_b = dec.b_sel_imm ? dec.imm : rs2_val;
	assign shamt = op_b[4:0];

	always_comb begin
		case (dec.alu_op)
			ALU_ADD: alu_out = op_a + op_b;
			ALU_SUB: alu_out = op_a - op_b;
			ALU_SLL: alu_out = op_a << shamt;
			ALU_SLT: alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
			ALU_SLTU: alu_out = {31'b0, op_a < op_b};
			ALU_XOR: alu_out = op_a ^ op_b;
			ALU_SRL: alu_out = op_a >> shamt;
			ALU_SRA: alu_out = $unsigned($signed(op_a) >>> shamt);
			ALU_OR: alu_out = op_a | op_b;
			ALU_AND: alu_out = op_a & op_b;
			ALU_PASS_B: alu_out = op_b;
			default: alu_out = '0;
		endcase
	end

	// branches always compare the two registers.
	assign br_eq = (rs1_val == rs2_val);
	assign br_lt = ($signed(rs1_val) < $signed(rs2_val));
	assign br_ltu = (rs1_val < rs2_val);

	always_comb begin
		case (dec.funct3)
			F3_BEQ: br_cond = br_eq;
			F3_BNE: br_cond = !br_eq;
			F3_BLT: br_cond = br_lt;
			F3_BGE: br_cond = !br_lt;
			F3_BLTU: br_cond = br_ltu;
			F3_BGEU: br_cond = !br_ltu;
			default: br_cond = 1'b0;
		endcase
	end

	assign pc_plus4 = pc + `XLEN'd4;
	assign pc_target = pc + dec.imm;
	assign jalr_target = (rs1_val + dec.imm) & ~`XLEN'd1;

	always_comb begin
		ex.result = (dec.is_jal || dec.is_jalr) ? pc_plus4 : alu_out; // link value.
		ex.taken = dec.is_jal || dec.is_jalr || (dec.is_branch && br_cond);
		ex.target = dec.is_jalr ? jalr_target : pc_target;
	end

endmodule

//--- hdl/register_file.sv
`include "core_defs.svh"

module register_file (
	input logic clk,
	input logic [4:0] rs1_addr,
	input logic [4:0] rs2_addr,
	output logic [`XLEN-1:0] rs1_val,
	output logic [`XLEN-1:0] rs2_val,
	input logic wb_en,
	input logic [4:0] wb_addr,
	input logic [`XLEN-1:0] wb_data,
	output logic [`XLEN-1:0] a0
);

	logic [`XLEN-1:0] regs [1:31]; // x0 has no storage.

	always_ff @(posedge clk) begin
		if (wb_en && wb_addr != 5'd0) begin
			regs[wb_addr] <= wb_data;
		end
	end

	always_comb begin
		if (rs1_addr == 5'd0) begin
			rs1_val = '0;
		end else begin
			rs1_val = regs[rs1_addr];
		end
	end

	always_comb begin
		if (rs2_addr == 5'd0) begin
			rs2_val = '0;
		end else begin
			rs2_val = regs[rs2_addr];
		end
	end

	assign a0 = regs[10];

endmodule

//--- hdl/decode_unit.sv
module decode_unit
	import rv_isa_pkg::*;
	import core_pkg::*;
(
	input rv_inst_u inst,
	output decoded_t dec
);

	logic [31:0] imm_i;
	logic [31:0] imm_s;
	logic [31:0] imm_b;
	logic [31:0] imm_u;
	logic [31:0] imm_j;
	inst_type_t fmt;

	assign imm_i = {{20{inst.i.imm[11]}}, inst.i.imm};
	assign imm_s = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
	assign imm_b = {{19{inst.b.imm12}}, inst.b.imm12, inst.b.imm11, inst.b.imm10_5,
		inst.b.imm4_1, 1'b0};
	assign imm_u = {inst.u.imm, 12'b0};
	assign imm_j = {{11{inst.j.imm20}}, inst.j.imm20, inst.j.imm19_12, inst.j.imm11,
		inst.j.imm10_1, 1'b0};

	// sub only exists in the register form, srai shares bit 30 with sra.
	function automatic alu_op_t alu_decode(input logic [2:0] f3, input logic alt,
		input logic reg_form);
		case (f3)
			F3_ADD_SUB: alu_decode = (alt && reg_form) ? ALU_SUB : ALU_ADD;
			F3_SLL: alu_decode = ALU_SLL;
			F3_SLT: alu_decode = ALU_SLT;
			F3_SLTU: alu_decode = ALU_SLTU;
			F3_XOR: alu_decode = ALU_XOR;
			F3_SRL_SRA: alu_decode = alt ? ALU_SRA : ALU_SRL;
			F3_OR: alu_decode = ALU_OR;
			default: alu_decode = ALU_AND;
		endcase
	endfunction

	always_comb begin
		dec = '0;
		fmt = TYPE_R;
		dec.rs1 = inst.r.rs1;
		dec.rs2 = inst.r.rs2;
		dec.rd = inst.r.rd;
		dec.funct3 = inst.r.funct3;
		dec.csr_addr = inst.i.imm;
		dec.alu_op = ALU_ADD;
		dec.csr_op = CSR_NONE;
		case (inst.r.opcode)
			OP: begin
				dec.alu_op = alu_decode(inst.r.funct3, inst.r.funct7[5], 1'b1);
				dec.reg_wen = 1'b1;
			end
			OP_IMM: begin
				fmt = TYPE_I;
				dec.alu_op = alu_decode(inst.r.funct3, inst.r.funct7[5], 1'b0);
				dec.b_sel_imm = 1'b1;
				dec.reg_wen = 1'b1;
			end
			LUI: begin
				fmt = TYPE_U;
				dec.alu_op = ALU_PASS_B;
				dec.b_sel_imm = 1'b1;
				dec.reg_wen = 1'b1;
			end
			AUIPC: begin
				fmt = TYPE_U;
				dec.a_sel_pc = 1'b1;
				dec.b_sel_imm = 1'b1;
				dec.reg_wen = 1'b1;
			end
			JAL: begin
				fmt = TYPE_J;
				dec.is_jal = 1'b1;
				dec.reg_wen = 1'b1;
			end
			JALR: begin
				fmt = TYPE_I;
				dec.is_jalr = 1'b1;
				dec.reg_wen = 1'b1;
			end
			BRANCH: begin
				fmt = TYPE_B;
				dec.is_branch = 1'b1;
			end
			SYSTEM: begin
				fmt = TYPE_I;
				case (inst.i.funct3)
					F3_PRIV: begin
						dec.is_ecall = (inst.i.imm == SYS_ECALL);
						dec.is_ebreak = (inst.i.imm == SYS_EBREAK);
						dec.is_mret = (inst.i.imm == SYS_MRET);
					end
					F3_CSRRW: dec.csr_op = CSR_WRITE;
					F3_CSRRS: dec.csr_op = CSR_SET;
					F3_CSRRC: dec.csr_op = CSR_CLEAR;
					default: dec.csr_op = CSR_NONE; // csr immediate forms unsupported.
				endcase
				dec.reg_wen = (dec.csr_op != CSR_NONE);
			end
			default: dec.reg_wen = 1'b0; // unknown opcode is a nop.
		endcase
		case (fmt)
			TYPE_I: dec.imm = imm_i;
			TYPE_S: dec.imm = imm_s;
			TYPE_B: dec.imm = imm_b;
			TYPE_U: dec.imm = imm_u;
			TYPE_J: dec.imm = imm_j;
			default: dec.imm = '0;
		endcase
		if (dec.rd == 5'd0) begin
			dec.reg_wen = 1'b0;
		end
	end

endmodule

//--- hdl/fetch_unit.sv
`include "core_defs.svh"

module fetch_unit
	import core_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic halt,
	input redirect_t branch_redirect,
	input redirect_t trap_redirect,
	output logic [`XLEN-1:0] pc
);

	logic [`XLEN-1:0] pc_plus4;
	logic [`XLEN-1:0] next_pc;

	assign pc_plus4 = pc + `XLEN'd4;

	always_comb begin
		if (halt) begin
			next_pc = pc; // parked after ebreak.
		end else if (trap_redirect.valid) begin
			next_pc = trap_redirect.target;
		end else if (branch_redirect.valid) begin
			next_pc = branch_redirect.target;
		end else begin
			next_pc = pc_plus4;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			pc <= `RESET_PC;
		end else begin
			pc <= next_pc;
		end
	end

endmodule

//--- hdl/core_pkg.sv
`include "core_defs.svh"

package core_pkg;

	typedef enum logic [2:0] {
		TYPE_R,
		TYPE_I,
		TYPE_S,
		TYPE_B,
		TYPE_U,
		TYPE_J
	} inst_type_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_PASS_B // lui.
	} alu_op_t;

	typedef enum logic [1:0] {
		CSR_NONE,
		CSR_WRITE,
		CSR_SET,
		CSR_CLEAR
	} csr_op_t;

	typedef struct packed {
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [4:0] rd;
		logic [`XLEN-1:0] imm;
		alu_op_t alu_op;
		logic a_sel_pc; // operand a is pc, else rs1.
		logic b_sel_imm; // operand b is imm, else rs2.
		logic is_branch;
		logic is_jal;
		logic is_jalr;
		logic [2:0] funct3; // branch condition.
		csr_op_t csr_op;
		logic [11:0] csr_addr;
		logic is_ecall;
		logic is_mret;
		logic is_ebreak;
		logic reg_wen;
	} decoded_t;

	typedef struct packed {
		logic [`XLEN-1:0] result;
		logic taken;
		logic [`XLEN-1:0] target;
	} exec_result_t;

	typedef struct packed {
		logic valid;
		logic [`XLEN-1:0] target;
	} redirect_t;

endpackage

//--- hdl/rv_isa_pkg.sv
package rv_isa_pkg;

	typedef enum logic [6:0] {
		OP     = 7'b0110011,
		OP_IMM = 7'b0010011,
		LUI    = 7'b0110111,
		AUIPC  = 7'b0010111,
		JAL    = 7'b1101111,
		JALR   = 7'b1100111,
		BRANCH = 7'b1100011,
		SYSTEM = 7'b1110011
	} opcode_e;

	// alu funct3.
	localparam logic [2:0] F3_ADD_SUB = 3'd0;
	localparam logic [2:0] F3_SLL     = 3'd1;
	localparam logic [2:0] F3_SLT     = 3'd2;
	localparam logic [2:0] F3_SLTU    = 3'd3;
	localparam logic [2:0] F3_XOR     = 3'd4;
	localparam logic [2:0] F3_SRL_SRA = 3'd5;
	localparam logic [2:0] F3_OR      = 3'd6;
	localparam logic [2:0] F3_AND     = 3'd7;

	// branch funct3.
	localparam logic [2:0] F3_BEQ  = 3'd0;
	localparam logic [2:0] F3_BNE  = 3'd1;
	localparam logic [2:0] F3_BLT  = 3'd4;
	localparam logic [2:0] F3_BGE  = 3'd5;
	localparam logic [2:0] F3_BLTU = 3'd6;
	localparam logic [2:0] F3_BGEU = 3'd7;

	// system funct3 and funct12.
	localparam logic [2:0] F3_PRIV  = 3'd0;
	localparam logic [2:0] F3_CSRRW = 3'd1;
	localparam logic [2:0] F3_CSRRS = 3'd2;
	localparam logic [2:0] F3_CSRRC = 3'd3;
	localparam logic [11:0] SYS_ECALL  = 12'h000;
	localparam logic [11:0] SYS_EBREAK = 12'h001;
	localparam logic [11:0] SYS_MRET   = 12'h302;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic imm11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm;
		logic [4:0] rd;
		logic [6:0] opcode;
	} u_fmt_t;

	typedef struct packed {
		logic imm20;
		logic [9:0] imm10_1;
		logic imm11;
		logic [7:0] imm19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
		u_fmt_t u;
		j_fmt_t j;
	} rv_inst_u;

endpackage

//--- hdl/core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

`define XLEN 32
`define RESET_PC 32'h8000_0000

// machine-mode csr addresses.
`define CSR_MTVEC 12'h305
`define CSR_MEPC 12'h341
`define CSR_MCAUSE 12'h342

`define MCAUSE_ECALL 32'd11 // environment call from m-mode.

`endif
